/* rtl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    localparam int ADDR_W = 32;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeT;

    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00, // address calc
        ALUOP_SUB   = 2'b01, // branch compare
        ALUOP_FUNCT = 2'b10  // funct or opcode decides
    } aluOpT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_NONE // result forced to zero
    } aluFnT;

    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        logic  memToReg;
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        aluOpT aluOp;
    } ctrlWordT;

    // one retire report per instruction
    typedef struct packed {
        logic              valid;
        logic              isStore;
        logic [ADDR_W-1:0] pc;
        logic [4:0]        dest;
        logic [ADDR_W-1:0] value;
    } traceT;

endpackage

`default_nettype wire

/* rtl/Controller.sv */
`timescale 1ns/1ps
`default_nettype none

module Controller (
    input  logic [5:0]        opcode,
    output mipsPkg::ctrlWordT ctrl
);
    import mipsPkg::*;

    always_comb begin
        ctrl = '0; // unsupported opcodes fall through as no-ops
        case (opcodeT'(opcode))
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end

            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end

            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = ALUOP_ADD;
            end

            OP_BEQ, OP_BNE: begin
                ctrl.branch = 1'b1; // polarity resolved in the sequencer
                ctrl.aluOp  = ALUOP_SUB;
            end

            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT; // alu picks op from opcode
            end

            OP_LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALUOP_FUNCT;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/AluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module AluUnit (
    input  mipsPkg::aluOpT              aluOp,
    input  logic [5:0]                  funct,
    input  logic [5:0]                  opcode,
    input  logic [mipsPkg::ADDR_W-1:0]  a,
    input  logic [mipsPkg::ADDR_W-1:0]  b,
    output logic [mipsPkg::ADDR_W-1:0]  result,
    output logic                        zero
);
    import mipsPkg::*;

    aluFnT fn;

    always_comb begin
        fn = ALU_NONE;
        case (aluOp)
            ALUOP_ADD: fn = ALU_ADD; // lw/sw address
            ALUOP_SUB: fn = ALU_SUB; // beq/bne
            ALUOP_FUNCT: begin
                if (opcodeT'(opcode) == OP_RTYPE) begin
                    case (funct)
                        6'b100000, 6'b100001: fn = ALU_ADD;  // add, addu
                        6'b100010, 6'b100011: fn = ALU_SUB;  // sub, subu
                        6'b100100:            fn = ALU_AND;
                        6'b100101:            fn = ALU_OR;
                        6'b100110:            fn = ALU_XOR;
                        6'b100111:            fn = ALU_NOR;
                        6'b101010:            fn = ALU_SLT;
                        6'b101011:            fn = ALU_SLTU;
                        default:              fn = ALU_NONE; // shifts etc
                    endcase
                end else begin
                    case (opcodeT'(opcode))
                        OP_ADDI, OP_ADDIU: fn = ALU_ADD;
                        OP_ANDI:           fn = ALU_AND;
                        OP_ORI:            fn = ALU_OR;
                        OP_XORI:           fn = ALU_XOR;
                        OP_SLTI:           fn = ALU_SLT;
                        OP_SLTIU:          fn = ALU_SLTU;
                        OP_LUI:            fn = ALU_LUI;
                        default:           fn = ALU_NONE;
                    endcase
                end
            end
            default: fn = ALU_NONE;
        endcase
    end

    always_comb begin
        case (fn)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = ADDR_W'($signed(a) < $signed(b));
            ALU_SLTU: result = ADDR_W'(a < b);
            ALU_LUI:  result = b << 16; // imm into upper half
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/RegFile.sv */
`timescale 1ns/1ps
`default_nettype none

module RegFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [4:0]                  rdAddrA,
    input  logic [4:0]                  rdAddrB,
    output logic [mipsPkg::ADDR_W-1:0]  rdDataA,
    output logic [mipsPkg::ADDR_W-1:0]  rdDataB,
    input  logic                        wrEn,
    input  logic [4:0]                  wrAddr,
    input  logic [mipsPkg::ADDR_W-1:0]  wrData
);
    import mipsPkg::*;

    logic [ADDR_W-1:0] regs [32];

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin // $zero stays hardwired
            regs[wrAddr] <= wrData;
        end
    end

    // $zero reads back as zero on both ports
    aZeroHeld: assert property (@(posedge clk) disable iff (rst)
        (rdAddrA != 5'd0 || rdDataA == '0) && (rdAddrB != 5'd0 || rdDataB == '0));

endmodule

`default_nettype wire

/* rtl/InstrSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module InstrSequencer #(
    parameter logic [mipsPkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  mipsPkg::ctrlWordT           ctrl,
    input  logic [mipsPkg::ADDR_W-1:0]  aluResult,
    input  logic                        zero,
    input  logic [mipsPkg::ADDR_W-1:0]  rdDataA,
    input  logic [mipsPkg::ADDR_W-1:0]  rdDataB,
    output logic [mipsPkg::ADDR_W-1:0]  instr,
    output logic [mipsPkg::ADDR_W-1:0]  aluA,
    output logic [mipsPkg::ADDR_W-1:0]  aluB,
    output logic                        regWrEn,
    output logic [4:0]                  regWrAddr,
    output logic [mipsPkg::ADDR_W-1:0]  regWrData,
    output logic [mipsPkg::ADDR_W-1:0]  memAddr,
    output logic [mipsPkg::ADDR_W-1:0]  memWrData,
    output logic                        memRe,
    output logic                        memWe,
    input  logic [mipsPkg::ADDR_W-1:0]  memRdData,
    output mipsPkg::traceT              trace
);
    import mipsPkg::*;

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB} stateT;

    stateT             state;
    stateT             stateNext;
    opcodeT            opcode;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pcIr; // address of the instruction in IR
    logic [ADDR_W-1:0] aluOut;
    logic [ADDR_W-1:0] immSext;
    logic [ADDR_W-1:0] immExt;
    logic [ADDR_W-1:0] brTarget;
    logic [15:0]       imm;
    logic              zeroExt;
    logic              brTaken;
    logic              retire;

    assign opcode  = opcodeT'(instr[31:26]);
    assign imm     = instr[15:0];
    assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
    assign immSext = {{(ADDR_W-16){imm[15]}}, imm};
    assign immExt  = zeroExt ? {{(ADDR_W-16){1'b0}}, imm} : immSext;

    // pc already points past the branch by EXEC
    assign brTarget = pc + (immSext << 2);
    assign brTaken  = ctrl.branch && (zero != (opcode == OP_BNE));

    assign aluA = rdDataA;
    assign aluB = ctrl.aluSrc ? immExt : rdDataB;

    always_comb begin
        stateNext = state;
        case (state)
            FETCH:  stateNext = DECODE;
            DECODE: stateNext = EXEC;
            EXEC: begin
                if (ctrl.memRead || ctrl.memWrite) begin
                    stateNext = MEM;
                end else if (ctrl.regWrite) begin
                    stateNext = WB;
                end else begin
                    stateNext = FETCH; // branch or no-op
                end
            end
            MEM:     stateNext = ctrl.memRead ? WB : FETCH;
            WB:      stateNext = FETCH;
            default: stateNext = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= stateNext;
            if (state == DECODE) begin
                pc <= pc + ADDR_W'(4);
            end else if (state == EXEC && brTaken) begin
                pc <= brTarget;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            instr <= memRdData; // fetch data lands one cycle after memRe
            pcIr  <= pc;
        end
        if (state == EXEC) begin
            aluOut <= aluResult;
        end
    end

    assign memRe     = (state == FETCH) || (state == MEM && ctrl.memRead);
    assign memWe     = (state == MEM) && ctrl.memWrite;
    assign memAddr   = (state == FETCH) ? pc : aluOut;
    assign memWrData = rdDataB;

    assign regWrEn   = (state == WB) && ctrl.regWrite;
    assign regWrAddr = ctrl.regDst ? instr[15:11] : instr[20:16];
    assign regWrData = ctrl.memToReg ? memRdData : aluOut;

    assign retire = (stateNext == FETCH) && (state == EXEC || state == MEM || state == WB);

    always_comb begin
        trace = '0;
        if (retire) begin
            trace.valid = 1'b1;
            trace.pc    = pcIr;
            if (state == MEM) begin
                trace.isStore = 1'b1;
                trace.value   = memWrData;
            end else if (state == WB) begin
                trace.dest  = regWrAddr;
                trace.value = regWrData;
            end
        end
    end

    aOneStrobe: assert property (@(posedge clk) disable iff (rst)
        !(memRe && memWe));

    // writeback only ever follows EXEC or a load's MEM cycle
    aWbOnly: assert property (@(posedge clk) disable iff (rst)
        regWrEn |-> $past(state) == EXEC || ($past(state) == MEM && ctrl.memRead));

endmodule

`default_nettype wire

/* rtl/MipsCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module MipsCpu #(
    parameter logic [mipsPkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [mipsPkg::ADDR_W-1:0]  memAddr,
    output logic [mipsPkg::ADDR_W-1:0]  memWrData,
    output logic                        memRe,
    output logic                        memWe,
    input  logic [mipsPkg::ADDR_W-1:0]  memRdData,
    output mipsPkg::traceT              trace
);
    import mipsPkg::*;

    ctrlWordT          ctrl;
    logic [ADDR_W-1:0] instr;
    logic [ADDR_W-1:0] aluA;
    logic [ADDR_W-1:0] aluB;
    logic [ADDR_W-1:0] aluResult;
    logic [ADDR_W-1:0] rdDataA;
    logic [ADDR_W-1:0] rdDataB;
    logic [ADDR_W-1:0] regWrData;
    logic [4:0]        regWrAddr;
    logic              regWrEn;
    logic              zero;

    Controller uCtrl (
        .opcode (instr[31:26]),
        .ctrl   (ctrl)
    );

    AluUnit uAlu (
        .aluOp  (ctrl.aluOp),
        .funct  (instr[5:0]),
        .opcode (instr[31:26]),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .zero   (zero)
    );

    RegFile uRegs (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (instr[25:21]), // rs
        .rdAddrB (instr[20:16]), // rt
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (regWrEn),
        .wrAddr  (regWrAddr),
        .wrData  (regWrData)
    );

    InstrSequencer #(
        .RESET_PC (RESET_PC)
    ) uSeq (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .zero      (zero),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .instr     (instr),
        .aluA      (aluA),
        .aluB      (aluB),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRe     (memRe),
        .memWe     (memWe),
        .memRdData (memRdData),
        .trace     (trace)
    );

endmodule

`default_nettype wire

/* dv/tbMipsCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsCpu;
    import mipsPkg::*;

    localparam int          NUM_INSTR = 200;
    localparam logic [31:0] START_PC  = 32'h0000_0000;
    localparam logic [31:0] PROG_END  = START_PC + 32'(4 * NUM_INSTR);

    logic        clk;
    logic        rst;
    logic [31:0] memAddr;
    logic [31:0] memWrData;
    logic        memRe;
    logic        memWe;
    logic [31:0] memRdData;
    traceT       trace;

    logic [31:0] mem [logic [31:0]];      // memory seen by the DUT
    logic [31:0] modelMem [logic [31:0]];
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic [15:0] lfsrState;

    MipsCpu #(
        .RESET_PC (START_PC)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRe     (memRe),
        .memWe     (memWe),
        .memRdData (memRdData),
        .trace     (trace)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] dutRead(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : fillWord(a);
    endfunction

    function automatic logic [31:0] modelRead(input logic [31:0] a);
        return modelMem.exists(a) ? modelMem[a] : fillWord(a);
    endfunction

    function automatic logic [5:0] pickFunct(input logic [3:0] k);
        case (k % 4'd10)
            4'd0:    return 6'h20; // add
            4'd1:    return 6'h21;
            4'd2:    return 6'h22; // sub
            4'd3:    return 6'h23;
            4'd4:    return 6'h24;
            4'd5:    return 6'h25;
            4'd6:    return 6'h26;
            4'd7:    return 6'h27; // nor
            4'd8:    return 6'h2a;
            default: return 6'h2b; // sltu
        endcase
    endfunction

    function automatic logic [5:0] immOpcode(input logic [3:0] k);
        case (k)
            4'd6:    return OP_ADDI;
            4'd7:    return OP_ADDIU;
            4'd8:    return OP_ANDI;
            4'd9:    return OP_ORI;
            4'd10:   return OP_XORI;
            4'd11:   return OP_SLTI;
            4'd12:   return OP_SLTIU;
            default: return OP_LUI;
        endcase
    endfunction

    task automatic buildProgram();
        logic [31:0] ins;
        logic [31:0] addr;
        logic [5:0]  op;
        logic [3:0]  sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int i = 0; i < NUM_INSTR; i++) begin
            sel = 4'(randBits(4));
            case (sel)
                4'd2, 4'd3: begin
                    rt = 5'(randBits(5));
                    imm = {2'b01, 8'h00, 4'(randBits(4)), 2'b00}; // 16 data words at 0x4000
                    op = (sel == 4'd2) ? OP_LW : OP_SW;
                    ins = {op, 5'd0, rt, imm};
                end
                4'd4, 4'd5: begin
                    rs = 5'(randBits(5));
                    rt = 5'(randBits(5));
                    if (randBits(1) == 32'd1) begin
                        rt = rs; // forces equal operands
                    end
                    imm = {13'd0, 3'(randBits(3))}; // short forward hop
                    op = (sel == 4'd4) ? OP_BEQ : OP_BNE;
                    ins = {op, rs, rt, imm};
                end
                4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13: begin
                    rs = (sel == 4'd13) ? 5'd0 : 5'(randBits(5));
                    rt = 5'(randBits(5));
                    imm = 16'(randBits(16));
                    ins = {immOpcode(sel), rs, rt, imm};
                end
                4'd14: begin
                    case (2'(randBits(2)))
                        2'd0:    op = 6'b000001;
                        2'd1:    op = 6'b000010;
                        2'd2:    op = 6'b000111;
                        default: op = 6'b011100;
                    endcase
                    ins = {op, 26'(randBits(26))};
                end
                default: begin
                    rs = 5'(randBits(5));
                    rt = 5'(randBits(5));
                    rd = 5'(randBits(5));
                    ins = {6'b000000, rs, rt, rd, 5'd0, pickFunct(4'(randBits(4)))};
                end
            endcase
            addr = START_PC + 32'(4 * i);
            mem[addr] = ins;
            modelMem[addr] = ins;
        end
    endtask

    // executes the instruction at modelPc, returns the retire report
    function automatic traceT refStep(output int lat);
        traceT       t;
        logic [31:0] ins;
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] nextPc;
        logic [5:0]  op;
        ins = modelRead(modelPc);
        op = ins[31:26];
        rsV = modelRegs[ins[25:21]];
        rtV = modelRegs[ins[20:16]];
        sImm = {{16{ins[15]}}, ins[15:0]};
        zImm = {16'h0000, ins[15:0]};
        nextPc = modelPc + 32'd4;
        lat = 4;
        t = '0;
        t.valid = 1'b1;
        t.pc = modelPc;
        t.dest = ins[20:16];
        case (op)
            OP_RTYPE: begin
                t.dest = ins[15:11];
                case (ins[5:0])
                    6'h20, 6'h21: t.value = rsV + rtV;
                    6'h22, 6'h23: t.value = rsV - rtV;
                    6'h24:        t.value = rsV & rtV;
                    6'h25:        t.value = rsV | rtV;
                    6'h26:        t.value = rsV ^ rtV;
                    6'h27:        t.value = ~(rsV | rtV);
                    6'h2a:        t.value = 32'($signed(rsV) < $signed(rtV));
                    6'h2b:        t.value = 32'(rsV < rtV);
                    default:      t.value = '0;
                endcase
            end
            OP_LW: begin
                lat = 5;
                t.value = modelRead(rsV + sImm);
            end
            OP_SW: begin
                modelMem[rsV + sImm] = rtV;
                t.isStore = 1'b1;
                t.dest = '0;
                t.value = rtV;
            end
            OP_BEQ, OP_BNE: begin
                lat = 3;
                t.dest = '0;
                if ((rsV == rtV) == (op == OP_BEQ)) begin
                    nextPc = nextPc + (sImm << 2);
                end
            end
            OP_ADDI, OP_ADDIU: t.value = rsV + sImm;
            OP_ANDI:           t.value = rsV & zImm;
            OP_ORI:            t.value = rsV | zImm;
            OP_XORI:           t.value = rsV ^ zImm;
            OP_SLTI:           t.value = 32'($signed(rsV) < $signed(sImm));
            OP_SLTIU:          t.value = 32'(rsV < sImm);
            OP_LUI:            t.value = {ins[15:0], 16'h0000};
            default: begin
                lat = 3; // unsupported, retires as a no-op
                t.dest = '0;
            end
        endcase
        if (!t.isStore && t.dest != 5'd0) begin
            modelRegs[t.dest] = t.value;
        end
        modelPc = nextPc;
        return t;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    always @(posedge clk) begin
        if (memWe === 1'b1) begin
            mem[memAddr] = memWrData;
        end
        if (memRe === 1'b1) begin
            memRdData <= dutRead(memAddr); // one cycle read latency
        end
    end

    initial begin
        traceT expTr;
        int    lat;
        int    cycles;
        int    reads;
        int    writes;
        int    retired;
        rst = 1'b1;
        memRdData = '0;
        lfsrState = 16'd11010;
        modelPc = START_PC;
        retired = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        buildProgram();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (modelPc < PROG_END) begin
            expTr = refStep(lat);
            cycles = 0;
            reads = 0;
            writes = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles == 1) begin
                    checkValue("fetch address", memAddr, expTr.pc);
                end
                if (memRe === 1'b1) begin
                    reads++;
                end
                if (memWe === 1'b1) begin
                    writes++;
                end
            end while (trace.valid !== 1'b1 && cycles < 20);
            if (trace.valid !== 1'b1) begin
                $display("timeout: no retire within 20 cycles for pc %h", expTr.pc);
                $display("** FAIL **");
                $fatal(1, "retire timeout");
            end
            checkValue("pc", trace.pc, expTr.pc);
            checkValue("isStore", 32'(trace.isStore), 32'(expTr.isStore));
            checkValue("dest", 32'(trace.dest), 32'(expTr.dest));
            checkValue("value", trace.value, expTr.value);
            checkValue("latency", 32'(cycles), 32'(lat));
            checkValue("memory reads", 32'(reads), (lat == 5) ? 32'd2 : 32'd1); // lw reads twice
            checkValue("memory writes", 32'(writes), 32'(expTr.isStore));
            retired++;
        end
        @(negedge clk); // last store lands on the edge before this
        checkValue("memory size", 32'(mem.num()), 32'(modelMem.num()));
        foreach (modelMem[a]) begin
            checkValue("memory word", dutRead(a), modelMem[a]);
        end
        $display("retired %0d instructions", retired);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/mipsPkg.sv
rtl/Controller.sv
rtl/AluUnit.sv
rtl/RegFile.sv
rtl/InstrSequencer.sv
rtl/MipsCpu.sv
dv/tbMipsCpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tbMipsCpu -o simTb

out=$(./obj_dir/simTb 2>&1) || true
echo "$out"
echo "$out" | grep -qF -- '** PASS **'
